/* hdl/render_pkg.sv */
package render_pkg;

    ////////////////////////////////////////////////////////////
    // Frame buffer geometry
    ////////////////////////////////////////////////////////////

    localparam int buffer_width  = 32;
    localparam int buffer_height = 24;
    localparam int buffer_pixels = buffer_width * buffer_height;

    // Pixel (x, y) lives at x + y * buffer_width.
    typedef logic [9:0] addr_t;

    // Colour is 4 bits each of red, green and blue.
    typedef logic [11:0] color_t;

    ////////////////////////////////////////////////////////////
    // Geometry types
    ////////////////////////////////////////////////////////////

    // Signed fixed point with 4 fraction bits.
    typedef logic signed [11:0] coord_t;

    // Integer pixel coordinate, may lie outside the buffer.
    typedef logic signed [8:0] screen_t;

    localparam int max_triangles = 8;

    // Wide enough to hold max_triangles itself.
    typedef logic [3:0] tri_index_t;

    // Quarter turns, counter-clockwise.
    typedef logic [1:0] rot_t;

    ////////////////////////////////////////////////////////////
    // Fixed colours
    ////////////////////////////////////////////////////////////

    localparam color_t bg_color_a       = 12'h222;
    localparam color_t bg_color_b       = 12'h024;
    localparam color_t marker_color_on  = 12'hF00;
    localparam color_t marker_color_off = 12'h00F;

    localparam addr_t marker_addr = addr_t'(buffer_pixels - 1);

endpackage

/* hdl/background_fill.sv */
`timescale 1ns/1ps

module background_fill (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start,
    input  logic               bg_select,
    output logic               write_en,
    output render_pkg::addr_t  write_addr,
    output render_pkg::color_t write_data,
    output logic               done
);
    import render_pkg::*;

    logic  busy;
    addr_t addr;

    // One address per cycle, starting the cycle after start.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            addr <= '0;
        end else if (start) begin
            busy <= 1'b1;
            addr <= '0;
        end else if (busy) begin
            if (addr == addr_t'(buffer_pixels - 1)) begin
                busy <= 1'b0;
            end
            addr <= addr + 1'b1;
        end
    end

    assign write_en   = busy;
    assign write_addr = addr;
    assign write_data = bg_select ? bg_color_b : bg_color_a;
    assign done       = busy && (addr == addr_t'(buffer_pixels - 1));

endmodule

/* hdl/model_store.sv */
`timescale 1ns/1ps

module model_store (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load_en,
    input  render_pkg::tri_index_t load_index,
    input  render_pkg::coord_t     load_ax,
    input  render_pkg::coord_t     load_ay,
    input  render_pkg::coord_t     load_bx,
    input  render_pkg::coord_t     load_by,
    input  render_pkg::coord_t     load_cx,
    input  render_pkg::coord_t     load_cy,
    input  render_pkg::color_t     load_color,
    input  render_pkg::tri_index_t read_index,
    output render_pkg::coord_t     ax,
    output render_pkg::coord_t     ay,
    output render_pkg::coord_t     bx,
    output render_pkg::coord_t     by,
    output render_pkg::coord_t     cx,
    output render_pkg::coord_t     cy,
    output render_pkg::color_t     color
);
    import render_pkg::*;

    // One entry holds six coordinates and the colour.
    typedef logic [6*$bits(coord_t)+$bits(color_t)-1:0] entry_t;

    entry_t mem [max_triangles];
    entry_t rd_q;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_index[2:0]] <= {load_ax, load_ay, load_bx, load_by,
                                     load_cx, load_cy, load_color};
        end
    end

    // Registered read, data follows read_index by one cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_q <= '0;
        end else begin
            rd_q <= mem[read_index[2:0]];
        end
    end

    assign {ax, ay, bx, by, cx, cy, color} = rd_q;

endmodule

/* hdl/vertex_transform.sv */
`timescale 1ns/1ps

module vertex_transform (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    output logic               in_ready,
    input  render_pkg::coord_t in_ax,
    input  render_pkg::coord_t in_ay,
    input  render_pkg::coord_t in_bx,
    input  render_pkg::coord_t in_by,
    input  render_pkg::coord_t in_cx,
    input  render_pkg::coord_t in_cy,
    input  render_pkg::color_t in_color,
    input  logic               in_last,
    input  render_pkg::rot_t   rot,
    input  render_pkg::coord_t pos_x,
    input  render_pkg::coord_t pos_y,
    output logic               out_valid,
    input  logic               out_ready,
    output render_pkg::coord_t out_ax,
    output render_pkg::coord_t out_ay,
    output render_pkg::coord_t out_bx,
    output render_pkg::coord_t out_by,
    output render_pkg::coord_t out_cx,
    output render_pkg::coord_t out_cy,
    output render_pkg::color_t out_color,
    output logic               out_last
);
    import render_pkg::*;

    // Rotated x, then y, of a point; quarter turns stay exact.
    function automatic coord_t rot_x(input coord_t x, input coord_t y, input rot_t r);
        case (r)
            2'd0:    return x;
            2'd1:    return -y;
            2'd2:    return -x;
            default: return y;
        endcase
    endfunction

    function automatic coord_t rot_y(input coord_t x, input coord_t y, input rot_t r);
        case (r)
            2'd0:    return y;
            2'd1:    return x;
            2'd2:    return -y;
            default: return -x;
        endcase
    endfunction

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Translation wraps at 12 bits.
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_ax    <= coord_t'(rot_x(in_ax, in_ay, rot) + pos_x);
            out_ay    <= coord_t'(rot_y(in_ax, in_ay, rot) + pos_y);
            out_bx    <= coord_t'(rot_x(in_bx, in_by, rot) + pos_x);
            out_by    <= coord_t'(rot_y(in_bx, in_by, rot) + pos_y);
            out_cx    <= coord_t'(rot_x(in_cx, in_cy, rot) + pos_x);
            out_cy    <= coord_t'(rot_y(in_cx, in_cy, rot) + pos_y);
            out_color <= in_color;
            out_last  <= in_last;
        end
    end

endmodule

/* hdl/screen_project.sv */
`timescale 1ns/1ps

module screen_project (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    output logic                in_ready,
    input  render_pkg::coord_t  in_ax,
    input  render_pkg::coord_t  in_ay,
    input  render_pkg::coord_t  in_bx,
    input  render_pkg::coord_t  in_by,
    input  render_pkg::coord_t  in_cx,
    input  render_pkg::coord_t  in_cy,
    input  render_pkg::color_t  in_color,
    input  logic                in_last,
    output logic                out_valid,
    input  logic                out_ready,
    output render_pkg::screen_t out_ax,
    output render_pkg::screen_t out_ay,
    output render_pkg::screen_t out_bx,
    output render_pkg::screen_t out_by,
    output render_pkg::screen_t out_cx,
    output render_pkg::screen_t out_cy,
    output render_pkg::color_t  out_color,
    output logic                out_last
);
    import render_pkg::*;

    // Arithmetic shift floors toward minus infinity.
    function automatic screen_t to_screen(input coord_t v);
        return screen_t'(v >>> 4);
    endfunction

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_ax    <= to_screen(in_ax);
            out_ay    <= to_screen(in_ay);
            out_bx    <= to_screen(in_bx);
            out_by    <= to_screen(in_by);
            out_cx    <= to_screen(in_cx);
            out_cy    <= to_screen(in_cy);
            out_color <= in_color;
            out_last  <= in_last;
        end
    end

endmodule

/* hdl/triangle_rasterizer.sv */
`timescale 1ns/1ps

module triangle_rasterizer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    output logic                in_ready,
    input  render_pkg::screen_t in_ax,
    input  render_pkg::screen_t in_ay,
    input  render_pkg::screen_t in_bx,
    input  render_pkg::screen_t in_by,
    input  render_pkg::screen_t in_cx,
    input  render_pkg::screen_t in_cy,
    input  render_pkg::color_t  in_color,
    input  logic                in_last,
    output logic                pixel_valid,
    output logic                pixel_covered,
    output render_pkg::addr_t   pixel_addr,
    output render_pkg::color_t  pixel_color,
    output logic                pixel_last
);
    import render_pkg::*;

    typedef enum logic [1:0] {
        ras_idle,
        ras_setup,
        ras_scan
    } ras_state_t;

    // Holds a cross product of two 10-bit differences.
    typedef logic signed [21:0] edge_t;

    function automatic edge_t edge_fn(input screen_t x0, input screen_t y0,
                                      input screen_t x1, input screen_t y1,
                                      input screen_t px, input screen_t py);
        edge_t dx;
        edge_t dy;
        dx = edge_t'(x1) - edge_t'(x0);
        dy = edge_t'(y1) - edge_t'(y0);
        return dx * (edge_t'(py) - edge_t'(y0)) - dy * (edge_t'(px) - edge_t'(x0));
    endfunction

    function automatic screen_t min3(input screen_t a, input screen_t b, input screen_t c);
        screen_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic screen_t max3(input screen_t a, input screen_t b, input screen_t c);
        screen_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    ras_state_t state;
    screen_t    ax, ay, bx, by, cx, cy;
    color_t     color_q;
    logic       last_q;
    screen_t    min_x, max_x, min_y, max_y;
    screen_t    cur_x, cur_y;
    logic       empty_q, flat_q;

    screen_t lo_x, hi_x, lo_y, hi_y;
    logic    box_empty;
    logic    final_pix;
    edge_t   e0, e1, e2;

    ////////////////////////////////////////////////////////////
    // Bounding box, clamped to the buffer
    ////////////////////////////////////////////////////////////

    always_comb begin
        lo_x = min3(ax, bx, cx);
        hi_x = max3(ax, bx, cx);
        lo_y = min3(ay, by, cy);
        hi_y = max3(ay, by, cy);
        if (lo_x < 0) lo_x = '0;
        if (lo_y < 0) lo_y = '0;
        if (hi_x > screen_t'(buffer_width - 1)) hi_x = screen_t'(buffer_width - 1);
        if (hi_y > screen_t'(buffer_height - 1)) hi_y = screen_t'(buffer_height - 1);
        box_empty = (lo_x > hi_x) || (lo_y > hi_y);
    end

    always_ff @(posedge clk) begin
        if (state == ras_idle && in_valid) begin
            {ax, ay, bx, by, cx, cy} <= {in_ax, in_ay, in_bx, in_by, in_cx, in_cy};
            color_q <= in_color;
            last_q  <= in_last;
        end
        if (state == ras_setup) begin
            {min_x, max_x, min_y, max_y} <= {lo_x, hi_x, lo_y, hi_y};
            empty_q <= box_empty;
            flat_q  <= (edge_fn(ax, ay, bx, by, cx, cy) == 0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Scan in raster order
    ////////////////////////////////////////////////////////////

    assign final_pix = empty_q || (cur_x == max_x && cur_y == max_y);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ras_idle;
            cur_x <= '0;
            cur_y <= '0;
        end else begin
            case (state)
                ras_idle: if (in_valid) state <= ras_setup;
                ras_setup: begin
                    // An empty box scans one dummy pixel at the origin.
                    cur_x <= box_empty ? screen_t'(0) : lo_x;
                    cur_y <= box_empty ? screen_t'(0) : lo_y;
                    state <= ras_scan;
                end
                default: begin
                    if (final_pix) begin
                        state <= ras_idle;
                    end else if (cur_x == max_x) begin
                        cur_x <= min_x;
                        cur_y <= cur_y + 1'b1;
                    end else begin
                        cur_x <= cur_x + 1'b1;
                    end
                end
            endcase
        end
    end

    assign e0 = edge_fn(ax, ay, bx, by, cur_x, cur_y);
    assign e1 = edge_fn(bx, by, cx, cy, cur_x, cur_y);
    assign e2 = edge_fn(cx, cy, ax, ay, cur_x, cur_y);

    assign in_ready      = (state == ras_idle);
    assign pixel_valid   = (state == ras_scan);
    // Same sign on all three edges covers both windings.
    assign pixel_covered = !empty_q && !flat_q
                           && ((e0 >= 0 && e1 >= 0 && e2 >= 0)
                               || (e0 <= 0 && e1 <= 0 && e2 <= 0));
    assign pixel_addr    = addr_t'(cur_y) * addr_t'(buffer_width) + addr_t'(cur_x);
    assign pixel_color   = color_q;
    assign pixel_last    = pixel_valid && final_pix && last_q;

endmodule

/* hdl/drawing_manager.sv */
`timescale 1ns/1ps

module drawing_manager (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   draw_start,
    input  logic                   draw_ack,
    input  render_pkg::tri_index_t triangle_count,
    input  render_pkg::rot_t       rot,
    input  render_pkg::coord_t     pos_x,
    input  render_pkg::coord_t     pos_y,
    input  logic                   bg_select,
    output render_pkg::rot_t       frame_rot,
    output render_pkg::coord_t     frame_pos_x,
    output render_pkg::coord_t     frame_pos_y,
    output logic                   frame_bg_select,
    output logic                   bg_start,
    input  logic                   bg_write_en,
    input  render_pkg::addr_t      bg_write_addr,
    input  render_pkg::color_t     bg_write_data,
    input  logic                   bg_done,
    output render_pkg::tri_index_t read_index,
    output logic                   tri_valid,
    input  logic                   tri_ready,
    output logic                   tri_last,
    input  logic                   pixel_valid,
    input  logic                   pixel_covered,
    input  render_pkg::addr_t      pixel_addr,
    input  render_pkg::color_t     pixel_color,
    input  logic                   pixel_last,
    output logic                   write_en,
    output render_pkg::addr_t      write_addr,
    output render_pkg::color_t     write_data,
    output logic                   frame_done
);
    import render_pkg::*;

    typedef enum logic [2:0] {
        state_idle,
        state_background,
        state_graphics,
        state_marker,
        state_frame_done
    } frame_state_t;

    frame_state_t state, next_state;
    tri_index_t   frame_count;
    logic         data_ok;
    logic         marker_on;
    logic         frame_start;

    assign frame_start = (state == state_idle && draw_start)
                         || (state == state_frame_done && draw_ack);

    // Frame settings stay fixed until the next frame starts.
    always_ff @(posedge clk) begin
        if (frame_start) begin
            frame_rot       <= rot;
            frame_pos_x     <= pos_x;
            frame_pos_y     <= pos_y;
            frame_bg_select <= bg_select;
            frame_count     <= triangle_count;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= state_idle;
            bg_start   <= 1'b0;
            read_index <= '0;
            data_ok    <= 1'b0;
            marker_on  <= 1'b0;
        end else begin
            state    <= next_state;
            bg_start <= frame_start;
            // Store data lags read_index by one cycle.
            data_ok  <= !(tri_valid && tri_ready);
            if (frame_start) begin
                read_index <= '0;
            end else if (tri_valid && tri_ready) begin
                read_index <= read_index + 1'b1;
            end
            if (state == state_marker) begin
                marker_on <= !marker_on;
            end
        end
    end

    assign tri_last = (read_index == tri_index_t'(frame_count - 1'b1));

    always_comb begin
        next_state = state;
        write_en   = 1'b0;
        write_addr = '0;
        write_data = '0;
        tri_valid  = 1'b0;
        frame_done = 1'b0;
        case (state)
            state_idle: begin
                if (draw_start) next_state = state_background;
            end
            state_background: begin
                write_en   = bg_write_en;
                write_addr = bg_write_addr;
                write_data = bg_write_data;
                if (bg_done) begin
                    next_state = (frame_count == '0) ? state_marker : state_graphics;
                end
            end
            state_graphics: begin
                tri_valid  = data_ok && (read_index < frame_count);
                write_en   = pixel_valid && pixel_covered;
                write_addr = pixel_addr;
                write_data = pixel_color;
                if (pixel_valid && pixel_last) next_state = state_marker;
            end
            state_marker: begin
                // Shows the toggled state, so the first frame writes "on".
                write_en   = 1'b1;
                write_addr = marker_addr;
                write_data = marker_on ? marker_color_off : marker_color_on;
                next_state = state_frame_done;
            end
            default: begin
                frame_done = 1'b1;
                if (draw_ack) next_state = state_background;
            end
        endcase
    end

endmodule

/* hdl/render_top.sv */
`timescale 1ns/1ps

module render_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   draw_start,
    input  logic                   draw_ack,
    input  logic                   load_en,
    input  render_pkg::tri_index_t load_index,
    input  render_pkg::coord_t     load_ax,
    input  render_pkg::coord_t     load_ay,
    input  render_pkg::coord_t     load_bx,
    input  render_pkg::coord_t     load_by,
    input  render_pkg::coord_t     load_cx,
    input  render_pkg::coord_t     load_cy,
    input  render_pkg::color_t     load_color,
    input  render_pkg::tri_index_t triangle_count,
    input  render_pkg::rot_t       rot,
    input  render_pkg::coord_t     pos_x,
    input  render_pkg::coord_t     pos_y,
    input  logic                   bg_select,
    output logic                   write_en,
    output render_pkg::addr_t      write_addr,
    output render_pkg::color_t     write_data,
    output logic                   frame_done
);
    import render_pkg::*;

    rot_t       frame_rot;
    coord_t     frame_pos_x, frame_pos_y;
    logic       frame_bg_select;
    logic       bg_start, bg_write_en, bg_done;
    addr_t      bg_write_addr;
    color_t     bg_write_data;
    tri_index_t read_index;
    logic       tri_valid, tri_ready, tri_last;
    coord_t     st_ax, st_ay, st_bx, st_by, st_cx, st_cy;
    color_t     st_color;

    ////////////////////////////////////////////////////////////
    // Pipeline links
    ////////////////////////////////////////////////////////////

    logic       tf_valid, tf_ready, tf_last;
    coord_t     tf_ax, tf_ay, tf_bx, tf_by, tf_cx, tf_cy;
    color_t     tf_color;
    logic       sp_valid, sp_ready, sp_last;
    screen_t    sp_ax, sp_ay, sp_bx, sp_by, sp_cx, sp_cy;
    color_t     sp_color;
    logic       pixel_valid, pixel_covered, pixel_last;
    addr_t      pixel_addr;
    color_t     pixel_color;

    drawing_manager u_manager (
        .clk, .rstn, .draw_start, .draw_ack, .triangle_count, .rot, .pos_x, .pos_y,
        .bg_select, .frame_rot, .frame_pos_x, .frame_pos_y, .frame_bg_select,
        .bg_start, .bg_write_en, .bg_write_addr, .bg_write_data, .bg_done,
        .read_index, .tri_valid, .tri_ready, .tri_last,
        .pixel_valid, .pixel_covered, .pixel_addr, .pixel_color, .pixel_last,
        .write_en, .write_addr, .write_data, .frame_done
    );

    background_fill u_background (
        .clk, .rstn, .start(bg_start), .bg_select(frame_bg_select),
        .write_en(bg_write_en), .write_addr(bg_write_addr),
        .write_data(bg_write_data), .done(bg_done)
    );

    model_store u_store (
        .clk, .rstn, .load_en, .load_index, .load_ax, .load_ay, .load_bx, .load_by,
        .load_cx, .load_cy, .load_color, .read_index,
        .ax(st_ax), .ay(st_ay), .bx(st_bx), .by(st_by), .cx(st_cx), .cy(st_cy),
        .color(st_color)
    );

    vertex_transform u_transform (
        .clk, .rstn, .in_valid(tri_valid), .in_ready(tri_ready),
        .in_ax(st_ax), .in_ay(st_ay), .in_bx(st_bx), .in_by(st_by),
        .in_cx(st_cx), .in_cy(st_cy), .in_color(st_color), .in_last(tri_last),
        .rot(frame_rot), .pos_x(frame_pos_x), .pos_y(frame_pos_y),
        .out_valid(tf_valid), .out_ready(tf_ready),
        .out_ax(tf_ax), .out_ay(tf_ay), .out_bx(tf_bx), .out_by(tf_by),
        .out_cx(tf_cx), .out_cy(tf_cy), .out_color(tf_color), .out_last(tf_last)
    );

    screen_project u_project (
        .clk, .rstn, .in_valid(tf_valid), .in_ready(tf_ready),
        .in_ax(tf_ax), .in_ay(tf_ay), .in_bx(tf_bx), .in_by(tf_by),
        .in_cx(tf_cx), .in_cy(tf_cy), .in_color(tf_color), .in_last(tf_last),
        .out_valid(sp_valid), .out_ready(sp_ready),
        .out_ax(sp_ax), .out_ay(sp_ay), .out_bx(sp_bx), .out_by(sp_by),
        .out_cx(sp_cx), .out_cy(sp_cy), .out_color(sp_color), .out_last(sp_last)
    );

    triangle_rasterizer u_raster (
        .clk, .rstn, .in_valid(sp_valid), .in_ready(sp_ready),
        .in_ax(sp_ax), .in_ay(sp_ay), .in_bx(sp_bx), .in_by(sp_by),
        .in_cx(sp_cx), .in_cy(sp_cy), .in_color(sp_color), .in_last(sp_last),
        .pixel_valid, .pixel_covered, .pixel_addr, .pixel_color, .pixel_last
    );

endmodule

/* dv/render_tb.sv */
`timescale 1ns/1ps

module render_tb;
    import render_pkg::*;

    localparam int reset_cycles = 10;
    localparam int frame_cycles = buffer_pixels + max_triangles * 800 + 100;
    localparam int ack_hold     = 3;

    logic       clk;
    logic       rstn;
    logic       draw_start;
    logic       draw_ack;
    logic       load_en;
    tri_index_t load_index;
    coord_t     load_ax, load_ay, load_bx, load_by, load_cx, load_cy;
    color_t     load_color;
    tri_index_t triangle_count;
    rot_t       rot;
    coord_t     pos_x, pos_y;
    logic       bg_select;
    logic       write_en;
    addr_t      write_addr;
    color_t     write_data;
    logic       frame_done;

    // Shadow copy of the frame buffer, built from the write port.
    color_t shadow [buffer_pixels];
    color_t loaded_color [max_triangles];

    int     frame_tris;
    color_t frame_bg;
    logic   frame_active   = 1'b0;
    int     bg_next        = 0;
    int     covered_count  = 0;
    logic   marker_seen    = 1'b0;
    logic   marker_on_next = 1'b1;
    logic   ack_given      = 1'b0;
    int     cycle_count    = 0;
    int     cycle_limit    = reset_cycles;

    render_top uut (
        .clk, .rstn, .draw_start, .draw_ack, .load_en, .load_index,
        .load_ax, .load_ay, .load_bx, .load_by, .load_cx, .load_cy, .load_color,
        .triangle_count, .rot, .pos_x, .pos_y, .bg_select,
        .write_en, .write_addr, .write_data, .frame_done
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reporting and helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, expected));
        end
    endtask

    // Only triangles drawn in this frame may supply a colour.
    function automatic logic color_loaded(input color_t c);
        for (int i = 0; i < frame_tris; i++) begin
            if (loaded_color[i] == c) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic load_triangle(input int idx, input int ax, input int ay, input int bx,
                                 input int by, input int cx, input int cy, input int col);
        @(posedge clk);
        load_en    <= 1'b1;
        load_index <= tri_index_t'(idx);
        load_ax    <= coord_t'(ax);
        load_ay    <= coord_t'(ay);
        load_bx    <= coord_t'(bx);
        load_by    <= coord_t'(by);
        load_cx    <= coord_t'(cx);
        load_cy    <= coord_t'(cy);
        load_color <= color_t'(col);
        @(posedge clk);
        load_en <= 1'b0;
        loaded_color[idx] = color_t'(col);
    endtask

    // The first frame leaves idle on draw_start, later ones on draw_ack.
    task automatic run_frame(input int count, input int rot_v, input int px, input int py,
                             input int sel, input int covered, input logic first);
        @(posedge clk);
        frame_tris     = count;
        frame_bg       = sel[0] ? bg_color_b : bg_color_a;
        bg_next        = 0;
        covered_count  = 0;
        marker_seen    = 1'b0;
        triangle_count <= tri_index_t'(count);
        rot            <= rot_t'(rot_v);
        pos_x          <= coord_t'(px);
        pos_y          <= coord_t'(py);
        bg_select      <= sel[0];
        if (first) begin
            frame_active = 1'b1;
            draw_start  <= 1'b1;
            @(posedge clk);
            draw_start  <= 1'b0;
        end else begin
            ack_given = 1'b1;
            draw_ack <= 1'b1;
            repeat (ack_hold) @(posedge clk);
            draw_ack <= 1'b0;
        end
        do @(negedge clk); while (frame_done !== 1'b1);
        check_value("covered writes", covered_count, covered);
    endtask

    ////////////////////////////////////////////////////////////
    // Write port monitor and timeout
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!frame_active) begin
            if (write_en !== 1'b0 || frame_done !== 1'b0) begin
                stop_run("write_en or frame_done went high before draw_start");
            end
        end else begin
            if (frame_done === 1'b1 && !marker_seen && !ack_given) begin
                stop_run("frame_done went high before the marker write");
            end
            if (frame_done !== 1'b1 && marker_seen) begin
                stop_run("frame_done dropped before draw_ack");
            end
            if (frame_done !== 1'b1) begin
                ack_given = 1'b0;
            end
            if (write_en === 1'b1) begin
                if (marker_seen) begin
                    stop_run("a write arrived after the marker write");
                end
                if (bg_next < buffer_pixels) begin
                    check_value("write_addr", write_addr, bg_next);
                    check_value("write_data", write_data, frame_bg);
                    bg_next = bg_next + 1;
                end else if (write_addr == marker_addr) begin
                    check_value("write_data", write_data,
                                marker_on_next ? marker_color_on : marker_color_off);
                    marker_on_next = !marker_on_next;
                    marker_seen    = 1'b1;
                end else begin
                    covered_count = covered_count + 1;
                    if (!color_loaded(write_data)) begin
                        stop_run("a triangle write carries a colour of no loaded triangle");
                    end
                end
                shadow[write_addr] = write_data;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        int                 fd;
        int                 n;
        int                 frames;
        logic [31:0]        tag;
        logic [8*128-1:0]   rest;
        int                 idx, ax, ay, bx, by, cx, cy, col;
        int                 count, rot_v, px, py, sel, covered;
        int                 x, y;
        logic               first_frame;

        rstn           <= 1'b0;
        draw_start     <= 1'b0;
        draw_ack       <= 1'b0;
        load_en        <= 1'b0;
        load_index     <= '0;
        load_ax        <= '0;
        load_ay        <= '0;
        load_bx        <= '0;
        load_by        <= '0;
        load_cx        <= '0;
        load_cy        <= '0;
        load_color     <= '0;
        triangle_count <= '0;
        rot            <= '0;
        pos_x          <= '0;
        pos_y          <= '0;
        bg_select      <= 1'b0;

        // First pass counts frames to size the timeout.
        fd = $fopen("dv/frame_input.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open dv/frame_input.txt");
        end
        frames = 0;
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "F") begin
                frames = frames + 1;
            end
            n = $fgets(rest, fd);
        end
        $fclose(fd);
        cycle_limit = reset_cycles + frames * frame_cycles;

        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;

        first_frame = 1'b1;
        fd = $fopen("dv/frame_input.txt", "r");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "L") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h", idx, ax, ay, bx, by, cx, cy, col);
                if (n != 8) begin
                    stop_run("malformed L line in dv/frame_input.txt");
                end
                load_triangle(idx, ax, ay, bx, by, cx, cy, col);
            end else if (tag == "F") begin
                n = $fscanf(fd, "%d %d %h %h %d %d", count, rot_v, px, py, sel, covered);
                if (n != 6) begin
                    stop_run("malformed F line in dv/frame_input.txt");
                end
                run_frame(count, rot_v, px, py, sel, covered, first_frame);
                first_frame = 1'b0;
            end else if (tag == "P") begin
                n = $fscanf(fd, "%d %d %h", x, y, col);
                if (n != 3) begin
                    stop_run("malformed P line in dv/frame_input.txt");
                end
                check_value($sformatf("pixel(%0d,%0d)", x, y),
                            shadow[x + y * buffer_width], col);
            end else begin
                stop_run("unknown line tag in dv/frame_input.txt");
            end
        end
        $fclose(fd);

        // Without an acknowledge the last frame must stay done and quiet.
        repeat (5) @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

/* dv/frame_input.txt */
# L index ax ay bx by cx cy color, all hex, coordinates with 4 fraction bits
# F count rot pos_x pos_y bg_select covered, pos in hex, the rest decimal
# P x y color, x and y decimal, color hex
L 0 000 000 040 000 000 040 f80
L 1 060 000 060 030 090 030 0f0
L 2 000 000 020 020 040 040 0ff
F 2 0 0a8 058 0 25
P 12 7 f80
P 13 7 222
P 19 8 0f0
F 2 1 140 0a0 1 25
P 10 5 024
P 18 12 f80
P 19 17 0f0
P 20 17 024
F 2 2 028 038 0 11
P 1 0 f80
P 0 0 222
P 31 23 f00
F 3 3 1c0 140 1 24
P 31 20 f80
P 30 18 f80
P 31 17 024
P 29 13 0f0
P 28 13 024
F 0 0 000 000 0 0
P 28 20 222
P 31 23 f00

/* all.f */
hdl/render_pkg.sv
hdl/background_fill.sv
hdl/model_store.sv
hdl/vertex_transform.sv
hdl/screen_project.sv
hdl/triangle_rasterizer.sv
hdl/drawing_manager.sv
hdl/render_top.sv
dv/render_tb.sv
